// ==== hdl/uart_baud_timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_config.svh"

module uart_baud_timer (
  input  wire  clk_i,
  input  wire  reset_i,
  input  wire  run_i,
  input  wire  restart_i,
  input  wire  half_i,
  output logic tick_o
);

  localparam int TIMER_BITS = `UART_TIMER_BITS;
  localparam logic [TIMER_BITS-1:0] LAST_COUNT = TIMER_BITS'(`UART_CLKS_PER_BIT - 1);
  localparam logic [TIMER_BITS-1:0] HALF_COUNT = TIMER_BITS'(`UART_CLKS_PER_BIT / 2);

  logic [TIMER_BITS-1:0] count_q;

  // one pulse per period, on the last count
  assign tick_o = run_i && (count_q == LAST_COUNT);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (restart_i) begin
      count_q <= half_i ? HALF_COUNT : '0;  // half load gives the mid-bit offset
    end else if (run_i) begin
      if (count_q == LAST_COUNT) begin
        count_q <= '0;  // wrap
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_core
  import uart_pkg::*;
(
  input  wire          clk_i,
  input  wire          reset_i,
  input  wire  [7:0]   tx_data_i,
  input  wire          tx_start_i,
  output logic         tx_o,
  output logic         tx_busy_o,
  input  wire          rx_i,
  input  wire          rx_pop_i,
  input  wire          clear_errors_i,
  output logic [7:0]   rx_data_o,
  output uart_status_t status_o
);

  logic      tx_tick;
  logic      tx_timer_run;
  logic      tx_timer_restart;
  logic      rx_tick;
  logic      rx_timer_run;
  logic      rx_timer_restart;
  logic      rx_timer_half;
  rx_event_t rx_event;

  uart_baud_timer tx_timer_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .run_i     (tx_timer_run),
    .restart_i (tx_timer_restart),
    .half_i    (1'b0),  // transmitter always uses full periods
    .tick_o    (tx_tick)
  );

  uart_transmitter transmitter_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .tx_data_i       (tx_data_i),
    .tx_start_i      (tx_start_i),
    .tick_i          (tx_tick),
    .timer_run_o     (tx_timer_run),
    .timer_restart_o (tx_timer_restart),
    .tx_o            (tx_o),
    .tx_busy_o       (tx_busy_o)
  );

  uart_baud_timer rx_timer_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .run_i     (rx_timer_run),
    .restart_i (rx_timer_restart),
    .half_i    (rx_timer_half),
    .tick_o    (rx_tick)
  );

  uart_receiver receiver_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .rx_i            (rx_i),
    .tick_i          (rx_tick),
    .timer_run_o     (rx_timer_run),
    .timer_restart_o (rx_timer_restart),
    .timer_half_o    (rx_timer_half),
    .event_o         (rx_event)
  );

  uart_rx_queue rx_queue_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .event_i        (rx_event),
    .rx_pop_i       (rx_pop_i),
    .clear_errors_i (clear_errors_i),
    .rx_data_o      (rx_data_o),
    .status_o       (status_o)
  );

endmodule

`default_nettype wire

// ==== hdl/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // transmitter frame phases
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  // receiver frame phases
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // one-cycle result of a received frame
  typedef struct packed {
    logic       byte_valid;   // stop bit was high
    logic       frame_error;  // stop bit was low
    logic [7:0] data;
  } rx_event_t;

  typedef struct packed {
    logic rx_empty;
    logic rx_full;
    logic overflow;     // sticky
    logic frame_error;  // sticky
  } uart_status_t;

endpackage

`default_nettype wire

// ==== hdl/uart_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_receiver
  import uart_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  wire       rx_i,
  input  wire       tick_i,
  output logic      timer_run_o,
  output logic      timer_restart_o,
  output logic      timer_half_o,
  output rx_event_t event_o
);

  rx_state_e  state_q;
  logic       rx_meta_q;
  logic       rx_sync_q;
  logic [7:0] shift_q;
  logic [2:0] bit_cnt_q;
  logic       valid_q;
  logic       ferr_q;
  logic       start_seen;

  // falling edge seen while idle
  assign start_seen = (state_q == RX_IDLE) && !rx_sync_q;

  assign timer_run_o     = (state_q != RX_IDLE);
  assign timer_restart_o = start_seen;
  assign timer_half_o    = start_seen;  // first tick lands mid start bit

  // two-flop synchronizer, resets to idle line level
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= RX_IDLE;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
      ferr_q    <= 1'b0;
    end else begin
      valid_q <= 1'b0;  // events are single pulses
      ferr_q  <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (start_seen) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (tick_i) begin
            // glitch rejection: line must still be low at mid-bit
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
            bit_cnt_q <= '0;
          end
        end
        RX_DATA: begin
          if (tick_i) begin
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        RX_STOP: begin
          if (tick_i) begin
            state_q <= RX_IDLE;
            valid_q <= rx_sync_q;   // good frame
            ferr_q  <= !rx_sync_q;  // stop bit low
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // data assembly, lsb arrives first
  always_ff @(posedge clk_i) begin
    if ((state_q == RX_DATA) && tick_i) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  // shift_q holds still until the next frame's data bits
  assign event_o = rx_event_t'{byte_valid: valid_q, frame_error: ferr_q, data: shift_q};

endmodule

`default_nettype wire

// ==== hdl/uart_rx_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_config.svh"

module uart_rx_queue
  import uart_pkg::*;
(
  input  wire            clk_i,
  input  wire            reset_i,
  input  wire rx_event_t event_i,
  input  wire            rx_pop_i,
  input  wire            clear_errors_i,
  output logic [7:0]     rx_data_o,
  output uart_status_t   status_o
);

  localparam int DEPTH    = `UART_RX_DEPTH;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);

  logic [7:0]          mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;
  logic                overflow_q;
  logic                ferr_q;
  logic                empty;
  logic                full;
  logic                do_pop;
  logic                do_push;

  assign empty   = (count_q == '0);
  assign full    = (count_q == CNT_BITS'(DEPTH));
  assign do_pop  = rx_pop_i && !empty;
  assign do_push = event_i.byte_valid && (!full || do_pop);  // a pop frees the slot

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= event_i.data;
    end
  end

  // sticky flags, a new error wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      overflow_q <= 1'b0;
      ferr_q     <= 1'b0;
    end else begin
      if (clear_errors_i) begin
        overflow_q <= 1'b0;
        ferr_q     <= 1'b0;
      end
      if (event_i.byte_valid && !do_push) begin
        overflow_q <= 1'b1;  // byte dropped
      end
      if (event_i.frame_error) begin
        ferr_q <= 1'b1;
      end
    end
  end

  assign rx_data_o = mem[rd_ptr_q];  // fall-through head
  assign status_o  = uart_status_t'{rx_empty: empty, rx_full: full,
                                    overflow: overflow_q, frame_error: ferr_q};

endmodule

`default_nettype wire

// ==== hdl/uart_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter
  import uart_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  wire [7:0] tx_data_i,
  input  wire       tx_start_i,
  input  wire       tick_i,
  output logic      timer_run_o,
  output logic      timer_restart_o,
  output logic      tx_o,
  output logic      tx_busy_o
);

  tx_state_e  state_q;
  logic [7:0] shift_q;
  logic [2:0] bit_cnt_q;
  logic       accept;

  // strobes while busy are dropped here
  assign accept          = (state_q == TX_IDLE) && tx_start_i;
  assign tx_busy_o       = (state_q != TX_IDLE);
  assign timer_run_o     = tx_busy_o;
  assign timer_restart_o = accept;  // start bit period begins at accept edge

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= TX_IDLE;
      tx_o      <= 1'b1;  // line idles high
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (accept) begin
            state_q <= TX_START;
            tx_o    <= 1'b0;  // start bit
          end
        end
        TX_START: begin
          if (tick_i) begin
            state_q   <= TX_DATA;
            tx_o      <= shift_q[0];
            bit_cnt_q <= '0;
          end
        end
        TX_DATA: begin
          if (tick_i) begin
            if (bit_cnt_q == 3'd7) begin
              state_q <= TX_STOP;
              tx_o    <= 1'b1;  // stop bit
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              tx_o      <= shift_q[1];  // next bit, lsb first
            end
          end
        end
        TX_STOP: begin
          if (tick_i) begin
            state_q <= TX_IDLE;
          end
        end
        default: begin
          state_q <= TX_IDLE;
          tx_o    <= 1'b1;
        end
      endcase
    end
  end

  // byte shift register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= tx_data_i;
    end else if ((state_q == TX_DATA) && tick_i) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== include/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// serial bit period in clk_i cycles, small for simulation
`define UART_CLKS_PER_BIT 8

// width of the baud counter, enough to hold UART_CLKS_PER_BIT - 1
`define UART_TIMER_BITS $clog2(`UART_CLKS_PER_BIT)

// receive queue entries
`define UART_RX_DEPTH 4

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module uart_core_tb \
  -Mdir "$BUILD_DIR" -o uart_core_tb

"./$BUILD_DIR/uart_core_tb" | tee "$LOG_FILE"

if grep -q "Testbench failed" "$LOG_FILE"; then
  echo "simulation reported a failure, see $LOG_FILE"
  exit 1
fi

// ==== src.f ====
+incdir+include
hdl/uart_pkg.sv
hdl/uart_baud_timer.sv
hdl/uart_transmitter.sv
hdl/uart_receiver.sv
hdl/uart_rx_queue.sv
hdl/uart_core.sv
verification/uart_core_properties.sv
verification/uart_core_tb.sv

// ==== verification/uart_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_config.svh"

module uart_core_properties
  import uart_pkg::*;
(
  input wire               clk_i,
  input wire               reset_i,
  input wire               tx_line_i,
  input wire               tx_busy_i,
  input wire uart_status_t status_i
);

  localparam int FRAME_CYCLES = 10 * `UART_CLKS_PER_BIT;

  int busy_len;  // cycles since busy rose

  always_ff @(posedge clk_i) begin
    if (reset_i || !tx_busy_i) begin
      busy_len <= 0;
    end else begin
      busy_len <= busy_len + 1;
    end
  end

  idle_line_high: assert property (@(posedge clk_i) disable iff (reset_i)
    !tx_busy_i |-> tx_line_i)
    else $error("tx line low while the transmitter is idle");

  busy_not_too_long: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_busy_i |-> busy_len < FRAME_CYCLES)
    else $error("tx busy held longer than one frame");

  busy_full_frame: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(tx_busy_i) |-> busy_len == FRAME_CYCLES)
    else $error("tx busy fell before a full frame");

  // never empty and full at once, and bytes are dropped only when full
  queue_status_consistent: assert property (@(posedge clk_i) disable iff (reset_i)
    !(status_i.rx_empty && status_i.rx_full) &&
    (!$rose(status_i.overflow) || $past(status_i.rx_full)))
    else $error("rx queue status flags are inconsistent");

endmodule

`default_nettype wire

// ==== verification/uart_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_config.svh"

module uart_core_tb
  import uart_pkg::*;
();

  localparam int CLKS = `UART_CLKS_PER_BIT;
  localparam int DEPTH = `UART_RX_DEPTH;
  localparam int FRAME_CYCLES = 10 * CLKS;
  // roughly 30 frames of traffic, the limit leaves wide margin
  localparam int TIMEOUT_CYCLES = 250 * FRAME_CYCLES;

  logic         clk;
  logic         reset;
  logic [7:0]   tx_data;
  logic         tx_start;
  logic         tx_line;
  logic         tx_busy;
  logic         rx_line;
  logic         rx_pop;
  logic         clear_errors;
  logic [7:0]   rx_data;
  uart_status_t status;
  logic         drv_line;      // serial frame driver
  logic         loopback_sel;  // rx fed from tx_o when set
  logic [31:0]  lcg_state;
  int           error_count;
  int           check_count;
  int           cycle_count;

  assign rx_line = loopback_sel ? tx_line : drv_line;

  uart_core uart_core_inst (
    .clk_i          (clk),
    .reset_i        (reset),
    .tx_data_i      (tx_data),
    .tx_start_i     (tx_start),
    .tx_o           (tx_line),
    .tx_busy_o      (tx_busy),
    .rx_i           (rx_line),
    .rx_pop_i       (rx_pop),
    .clear_errors_i (clear_errors),
    .rx_data_o      (rx_data),
    .status_o       (status)
  );

  bind uart_core uart_core_properties properties_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .tx_line_i (tx_o),
    .tx_busy_i (tx_busy_o),
    .status_i  (status_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // watchdog on the cycle count
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("summary: %0d checks, %0d errors", check_count, error_count);
    $display("Testbench failed");
    $finish;
  end

  task automatic compare_value(input string test, input string what,
                               input int expected, input int actual);
    check_count++;
    assert (actual == expected) else begin
      $display("mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
               test, what, expected, actual);
      error_count++;
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_random_byte(output logic [7:0] value);
    lcg_state = lcg_next(lcg_state);
    value = lcg_state[23:16];  // better mixed than the low bits
  endtask

  function automatic logic condition_met(input string what);
    case (what)
      "byte":        return !status.rx_empty;
      "frame_error": return status.frame_error;
      "overflow":    return status.overflow;
      "tx_idle":     return !tx_busy;
      default:       return 1'b0;
    endcase
  endfunction

  // polls at the falling edge, where outputs are settled
  task automatic wait_until(input string test, input string what, input int limit);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!condition_met(what) && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    check_count++;
    assert (condition_met(what)) else begin
      $display("error in %s: no %s within %0d cycles", test, what, limit);
      error_count++;
    end
  endtask

  task automatic start_transmit(input logic [7:0] value);
    @(posedge clk);
    tx_data  <= value;
    tx_start <= 1'b1;
    @(posedge clk);
    tx_start <= 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] value, input logic stop_level);
    logic [9:0] bits;
    bits = {stop_level, value, 1'b0};  // start bit goes out first
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      drv_line <= bits[i];
      repeat (CLKS - 1) @(posedge clk);
    end
    @(posedge clk);
    drv_line <= 1'b1;
  endtask

  task automatic pop_byte();
    @(posedge clk);
    rx_pop <= 1'b1;
    @(posedge clk);
    rx_pop <= 1'b0;
  endtask

  task automatic clear_flags();
    @(posedge clk);
    clear_errors <= 1'b1;
    @(posedge clk);
    clear_errors <= 1'b0;
  endtask

  task automatic capture_frame(output logic [7:0] value, output logic start_level,
                               output logic stop_level);
    int waited;
    waited = 0;
    value = '0;
    @(negedge clk);
    while (tx_line && waited < 2 * FRAME_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    repeat (CLKS / 2 - 1) @(negedge clk);  // centre of start bit
    start_level = tx_line;
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS) @(negedge clk);
      value[i] = tx_line;
    end
    repeat (CLKS) @(negedge clk);
    stop_level = tx_line;
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    compare_value("reset", "tx_o", 1, int'(tx_line));
    compare_value("reset", "tx_busy_o", 0, int'(tx_busy));
    compare_value("reset", "rx_empty", 1, int'(status.rx_empty));
    compare_value("reset", "overflow", 0, int'(status.overflow));
    compare_value("reset", "frame_error", 0, int'(status.frame_error));
  endtask

  task automatic test_transmit();
    logic [7:0] value;
    logic [7:0] seen;
    logic       start_level;
    logic       stop_level;
    int         rise_cycle;
    for (int n = 0; n < 4; n++) begin
      if (n == 0) begin
        value = 8'h55;
      end else if (n == 1) begin
        value = 8'h80;
      end else begin
        next_random_byte(value);
      end
      start_transmit(value);
      @(negedge clk);
      rise_cycle = cycle_count;
      fork
        capture_frame(seen, start_level, stop_level);
        begin
          repeat (3 * CLKS) @(posedge clk);
          start_transmit(~value);  // lands while busy
        end
      join
      wait_until("transmit", "tx_idle", FRAME_CYCLES);
      compare_value("transmit", "start bit", 0, int'(start_level));
      compare_value("transmit", "data", int'(value), int'(seen));
      compare_value("transmit", "stop bit", 1, int'(stop_level));
      compare_value("transmit", "busy cycles", FRAME_CYCLES, cycle_count - rise_cycle);
      repeat (2 * CLKS) @(negedge clk);
      compare_value("transmit", "busy after frame", 0, int'(tx_busy));
    end
  endtask

  task automatic test_receive();
    logic [7:0] value;
    for (int n = 0; n < 4; n++) begin
      next_random_byte(value);
      send_frame(value, 1'b1);
      wait_until("receive", "byte", 4 * CLKS);
      compare_value("receive", "rx_data", int'(value), int'(rx_data));
      pop_byte();
      @(negedge clk);
      compare_value("receive", "rx_empty after pop", 1, int'(status.rx_empty));
    end
  endtask

  task automatic test_framing_error();
    logic [7:0] value;
    next_random_byte(value);
    send_frame(value, 1'b0);
    wait_until("framing", "frame_error", 4 * CLKS);
    repeat (CLKS) @(negedge clk);  // low stop bit looks like a start, rejected
    compare_value("framing", "rx_empty", 1, int'(status.rx_empty));
    clear_flags();
    @(negedge clk);
    compare_value("framing", "frame_error after clear", 0, int'(status.frame_error));
  endtask

  task automatic test_overflow();
    logic [7:0] sent [DEPTH + 1];
    for (int n = 0; n <= DEPTH; n++) begin
      next_random_byte(sent[n]);
      send_frame(sent[n], 1'b1);
    end
    wait_until("overflow", "overflow", 4 * CLKS);
    compare_value("overflow", "rx_full", 1, int'(status.rx_full));
    for (int n = 0; n < DEPTH; n++) begin
      compare_value("overflow", "rx_data", int'(sent[n]), int'(rx_data));
      pop_byte();
      @(negedge clk);
    end
    compare_value("overflow", "rx_empty", 1, int'(status.rx_empty));
    clear_flags();
    @(negedge clk);
    compare_value("overflow", "overflow after clear", 0, int'(status.overflow));
  endtask

  task automatic test_loopback();
    logic [7:0] value;
    @(posedge clk);
    loopback_sel <= 1'b1;
    for (int n = 0; n < 16; n++) begin
      next_random_byte(value);
      start_transmit(value);
      wait_until("loopback", "byte", 2 * FRAME_CYCLES);
      compare_value("loopback", "rx_data", int'(value), int'(rx_data));
      pop_byte();
      wait_until("loopback", "tx_idle", FRAME_CYCLES);
    end
    @(posedge clk);
    loopback_sel <= 1'b0;
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
    lcg_state = 32'h9ab21ffe;
    reset        <= 1'b1;
    tx_data      <= '0;
    tx_start     <= 1'b0;
    rx_pop       <= 1'b0;
    clear_errors <= 1'b0;
    drv_line     <= 1'b1;  // idle line
    loopback_sel <= 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_transmit();
    test_receive();
    test_framing_error();
    test_overflow();
    test_loopback();
    repeat (2) @(negedge clk);
    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
